//--- hdl/buck_pkg.sv
package buck_pkg;

    // Number of physical power stages on the board
    localparam int n_phases = 4;

    // Duty and period words share one width so they compare directly
    localparam int duty_width = 16;

    // A phase count runs from 0 to n_phases inclusive
    localparam int count_width = $clog2(n_phases + 1);

    // Minimum spacing in clocks between two changes of the active count
    // Gives the current loops time to absorb one phase before the next
    localparam int settle_cycles = 8;

    // Duty words are signed because the compensators may ask for
    // a negative correction on top of the feedforward
    typedef logic signed [duty_width-1:0] duty_t;

    // Word written by the host through the req/ack port
    typedef struct packed {
        // Switching period in clocks
        logic [duty_width-1:0] period;
        // Number of phases the host wants running
        logic [count_width-1:0] phase_request;
    } config_t;

    // Active phase count and its one-cycle change strobes
    typedef struct packed {
        // Number of phases currently switching
        logic [count_width-1:0] active;
        // High for one cycle when active has just risen by one
        logic added;
        // High for one cycle when active has just fallen by one
        logic shed;
    } phase_step_t;

    // One duty word per phase, phase 0 in the low word
    typedef duty_t [n_phases-1:0] duty_vec_t;

endpackage

//--- hdl/phase_config_port.sv
`timescale 1ns/1ns

module phase_config_port (
    input  logic              clock,
    input  logic              reset,
    input  logic              cfg_req,
    input  buck_pkg::config_t cfg_data,
    output logic              cfg_ack,
    output buck_pkg::config_t cfg
);
    import buck_pkg::*;

    // Request after one register stage
    // The protocol runs only on this copy
    logic req_sync;

    // Phase request forced into the range 1 to n_phases
    logic [count_width-1:0] request_clamped;

    // Phase 0 always runs, so a request of zero still means one phase
    // A request above the number of stages asks for all of them
    always_comb begin
        if (cfg_data.phase_request > count_width'(n_phases)) begin
            request_clamped = count_width'(n_phases);
        end else if (cfg_data.phase_request == '0) begin
            request_clamped = count_width'(1);
        end else begin
            request_clamped = cfg_data.phase_request;
        end
    end

    // Four-phase handshake
    // Ack goes high one cycle after the synchronized req is seen high,
    // which is two cycles after the host raises req
    // Ack falls one cycle after the synchronized req is seen low
    always_ff @(posedge clock) begin
        if (reset) begin
            req_sync <= 1'b0;
            cfg_ack <= 1'b0;
            // Period of zero keeps every gate low until the host writes
            cfg.period <= '0;
            cfg.phase_request <= count_width'(1);
        end else begin
            req_sync <= cfg_req;
            if (req_sync && !cfg_ack) begin
                // Data is stable while req is high, so capture it here
                // The new word is valid from the same cycle as ack
                cfg_ack <= 1'b1;
                cfg.period <= cfg_data.period;
                cfg.phase_request <= request_clamped;
            end else if (!req_sync && cfg_ack) begin
                // Host has released req, so close the transfer
                cfg_ack <= 1'b0;
            end
        end
    end

endmodule

//--- hdl/phase_sequencer.sv
`timescale 1ns/1ns

module phase_sequencer (
    input  logic                               clock,
    input  logic                               reset,
    input  logic [buck_pkg::count_width-1:0]   request,
    output buck_pkg::phase_step_t              step
);
    import buck_pkg::*;

    // Clocks since the last change of the active count
    // It stops counting once the settle interval has elapsed
    logic [$clog2(settle_cycles)-1:0] settle_count;

    // High once enough clocks have passed to allow another step
    logic settled;

    // A change at edge t lets the next one happen at edge t+settle_cycles
    assign settled = (settle_count == $bits(settle_count)'(settle_cycles - 1));

    // The active count moves by one toward the request per step
    // Only one phase is ever added or shed at a time, so the
    // shedding manager seeds a single feedforward per event
    always_ff @(posedge clock) begin
        if (reset) begin
            step.active <= count_width'(1);
            step.added <= 1'b0;
            step.shed <= 1'b0;
            // Start settled so the first request is served at once
            settle_count <= $bits(settle_count)'(settle_cycles - 1);
        end else begin
            // Strobes last one cycle only
            step.added <= 1'b0;
            step.shed <= 1'b0;

            if (!settled) begin
                settle_count <= settle_count + 1'b1;
            end

            if (settled && (request > step.active)) begin
                // Bring one more phase online
                step.active <= step.active + 1'b1;
                step.added <= 1'b1;
                settle_count <= '0;
            end else if (settled && (request < step.active)) begin
                // Drop the highest running phase
                step.active <= step.active - 1'b1;
                step.shed <= 1'b1;
                settle_count <= '0;
            end
            // A request that already matches leaves everything alone
        end
    end

endmodule

//--- hdl/shedding_manager.sv
`timescale 1ns/1ns

module shedding_manager (
    input  logic                              clock,
    input  logic                              reset,
    input  logic [buck_pkg::duty_width-1:0]   period,
    input  buck_pkg::phase_step_t             step,
    input  buck_pkg::duty_vec_t               duty_in,
    output buck_pkg::duty_vec_t               duty_out
);
    import buck_pkg::*;

    // Feedforward per phase
    // Phase 0 is the reference and carries none
    duty_t ff [1:n_phases-1];

    // Correction plus feedforward, two bits wider so that neither
    // the sign nor the carry is lost
    logic signed [duty_width+1:0] sum [1:n_phases-1];

    // Period as a positive value in the same width as the sums
    logic signed [duty_width+1:0] period_ext;

    // Saturated duty for each of the upper phases
    duty_t sat [1:n_phases-1];

    assign period_ext = {2'b00, period};

    // Clamp each sum into the range from 0 to period-1
    // The feedforward is a copy of a running duty, so in practice
    // only a large negative correction drives the sum below zero
    always_comb begin
        for (int i = 1; i < n_phases; i++) begin
            sum[i] = (duty_width + 2)'(duty_in[i]) + (duty_width + 2)'(ff[i]);
            if (sum[i] < 0) begin
                sat[i] = '0;
            end else if (sum[i] >= period_ext) begin
                sat[i] = duty_t'(period - 1'b1);
            end else begin
                sat[i] = duty_t'(sum[i]);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 1; i < n_phases; i++) begin
                ff[i] <= '0;
            end
            duty_out <= '0;
        end else begin
            // The step carries the new count, so the phase that just
            // came online is active-1 and the one just dropped is active
            // A new phase starts from the duty of phase 0 so that it
            // shares the load right away
            if (step.added) begin
                ff[step.active - 1'b1] <= duty_in[0];
            end else if (step.shed) begin
                ff[step.active] <= '0;
            end

            // Phase 0 is the master phase and passes straight through
            duty_out[0] <= duty_in[0];
            // Upper phases are computed even while inactive
            // The carrier gates them off
            for (int i = 1; i < n_phases; i++) begin
                duty_out[i] <= sat[i];
            end
        end
    end

endmodule

//--- hdl/pwm_carrier.sv
`timescale 1ns/1ns

module pwm_carrier (
    input  logic                              clock,
    input  logic                              reset,
    input  logic [buck_pkg::duty_width-1:0]   period,
    input  logic [buck_pkg::count_width-1:0]  active,
    input  buck_pkg::duty_vec_t               duty,
    output logic [buck_pkg::n_phases-1:0]     gate
);
    import buck_pkg::*;

    // Shared up-counter that runs from 0 to period-1
    logic [duty_width-1:0] master;

    // Phase shift of each carrier, period*i/n_phases
    logic [duty_width-1:0] offset [n_phases];

    // Master plus offset before the wrap, one bit wider for the carry
    logic [duty_width:0] shifted [n_phases];

    // Carrier count of each phase after the modular wrap
    logic [duty_width-1:0] carrier [n_phases];

    // Master counter
    // A period that shrinks below the current count also wraps it
    always_ff @(posedge clock) begin
        if (reset) begin
            master <= '0;
        end else if ((period == '0) || (master >= period - 1'b1)) begin
            master <= '0;
        end else begin
            master <= master + 1'b1;
        end
    end

    // Spread the carriers evenly over one period
    // Both operands of the add are below period, so one subtraction wraps it
    always_comb begin
        for (int i = 0; i < n_phases; i++) begin
            offset[i] = duty_width'((32'(period) * i) / n_phases);
            shifted[i] = {1'b0, master} + {1'b0, offset[i]};
            if (shifted[i] >= {1'b0, period}) begin
                carrier[i] = duty_width'(shifted[i] - {1'b0, period});
            end else begin
                carrier[i] = duty_width'(shifted[i]);
            end
        end
    end

    // Gate is high while the carrier is below the duty
    // Compare signed so that a negative duty keeps the gate off
    // Shed phases and an unconfigured period force the gate low
    always_ff @(posedge clock) begin
        if (reset) begin
            gate <= '0;
        end else begin
            for (int i = 0; i < n_phases; i++) begin
                gate[i] <= (i < active) && (period != '0)
                           && ($signed({1'b0, carrier[i]}) < duty[i]);
            end
        end
    end

endmodule

//--- hdl/buck_phase_top.sv
`timescale 1ns/1ns

module buck_phase_top (
    input  logic                              clock,
    input  logic                              reset,
    input  logic                              cfg_req,
    input  buck_pkg::config_t                 cfg_data,
    output logic                              cfg_ack,
    input  buck_pkg::duty_vec_t               duty_in,
    output buck_pkg::duty_vec_t               duty_out,
    output logic [buck_pkg::count_width-1:0]  active,
    output logic [buck_pkg::n_phases-1:0]     gate
);
    import buck_pkg::*;

    // Configuration word held by the port after each write
    config_t cfg;

    // Active count with its add and shed strobes
    phase_step_t step;

    // Host side of the converter
    phase_config_port config_port (
        .clock    (clock),
        .reset    (reset),
        .cfg_req  (cfg_req),
        .cfg_data (cfg_data),
        .cfg_ack  (cfg_ack),
        .cfg      (cfg)
    );

    // Moves the running phase count toward the request
    phase_sequencer sequencer (
        .clock   (clock),
        .reset   (reset),
        .request (cfg.phase_request),
        .step    (step)
    );

    // Feedforward seeding and duty saturation
    shedding_manager manager (
        .clock    (clock),
        .reset    (reset),
        .period   (cfg.period),
        .step     (step),
        .duty_in  (duty_in),
        .duty_out (duty_out)
    );

    // Interleaved PWM for the running phases
    pwm_carrier carrier (
        .clock  (clock),
        .reset  (reset),
        .period (cfg.period),
        .active (step.active),
        .duty   (duty_out),
        .gate   (gate)
    );

    // Running phase count for telemetry
    assign active = step.active;

endmodule

//--- tb/buck_phase_assertions.sv
`timescale 1ns/1ns

module buck_phase_assertions (
    input logic              clock,
    input logic              reset,
    input logic              cfg_req,
    input buck_pkg::config_t cfg_data,
    input logic              cfg_ack
);

    // Count of failed assertions, summed into the result of the run
    int failures = 0;

    // The port only answers a request that is still being held
    // Ack rises two clocks after req, and the host keeps req up until it sees ack
    ack_follows_req: assert property (
        @(posedge clock) disable iff (reset)
        $rose(cfg_ack) |-> cfg_req
    ) else begin
        failures++;
        $error("cfg_ack rose while cfg_req was low");
    end

    // The host releases req only once the port has acknowledged it
    req_held_until_ack: assert property (
        @(posedge clock) disable iff (reset)
        $fell(cfg_req) |-> cfg_ack
    ) else begin
        failures++;
        $error("cfg_req fell before cfg_ack was high");
    end

    // The config word must not move while a transfer is open
    // The first clock of a request is exempt since data and req change together
    data_stable_during_req: assert property (
        @(posedge clock) disable iff (reset)
        (cfg_req && $past(cfg_req)) |-> $stable(cfg_data)
    ) else begin
        failures++;
        $error("cfg_data changed while cfg_req was high");
    end

    // Ack stays up until the host has let go of req
    ack_held_until_release: assert property (
        @(posedge clock) disable iff (reset)
        $fell(cfg_ack) |-> !cfg_req
    ) else begin
        failures++;
        $error("cfg_ack fell while cfg_req was still high");
    end

endmodule

//--- tb/tb_buck_phase.sv
`timescale 1ns/1ns

module tb_buck_phase;
    import buck_pkg::*;

    logic                   clock;
    logic                   reset;
    logic                   cfg_req;
    config_t                cfg_data;
    logic                   cfg_ack;
    duty_vec_t              duty_in;
    duty_vec_t              duty_out;
    logic [count_width-1:0] active;
    logic [n_phases-1:0]    gate;

    // Stimulus lines without comments or blank lines
    string commands [$];

    // Run length allowed by the watchdog, zero until the file is loaded
    int watchdog_cycles = 0;

    // Period last written to the DUT, used to size a gate measurement
    logic [duty_width-1:0] current_period = '0;

    // Totals over the whole run
    int checks = 0;
    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;

    // State of the test that is currently open
    string test_name = "";
    bit test_open = 1'b0;
    int test_checks = 0;
    int test_errors = 0;

    // Step monitor state
    logic [count_width-1:0] last_active;
    int cycles_since_step;

    buck_phase_top dut (
        .clock    (clock),
        .reset    (reset),
        .cfg_req  (cfg_req),
        .cfg_data (cfg_data),
        .cfg_ack  (cfg_ack),
        .duty_in  (duty_in),
        .duty_out (duty_out),
        .active   (active),
        .gate     (gate)
    );

    // Handshake checks sit inside the config port itself
    bind phase_config_port buck_phase_assertions handshake_checks (
        .clock    (clock),
        .reset    (reset),
        .cfg_req  (cfg_req),
        .cfg_data (cfg_data),
        .cfg_ack  (cfg_ack)
    );

    // 4 ns clock
    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    task automatic count_error;
        errors++;
        test_errors++;
    endtask

    // Report the open test, if any, on a line of its own
    task automatic close_test;
        if (test_open) begin
            if (test_errors == 0) begin
                $display("Test %s passed, %0d checks", test_name, test_checks);
            end else begin
                $display("Test %s failed with %0d errors in %0d checks",
                         test_name, test_errors, test_checks);
                tests_failed++;
            end
            test_open = 1'b0;
        end
    endtask

    task automatic open_test(input string name);
        close_test();
        test_name = name;
        test_open = 1'b1;
        test_checks = 0;
        test_errors = 0;
        tests_run++;
    endtask

    // Closing line with the counts, then the verdict
    task automatic report_summary;
        close_test();
        // Failed handshake assertions in the bound checker count as errors
        if (dut.config_port.handshake_checks.failures != 0) begin
            $display("Handshake assertions failed %0d times",
                     dut.config_port.handshake_checks.failures);
            errors += dut.config_port.handshake_checks.failures;
        end
        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    endtask

    // Lines starting with # are column notes
    task automatic load_stimulus;
        int fd;
        string line;
        string word;
        fd = $fopen("tb/buck_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file tb/buck_stimulus.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) > 0) begin
                    if (($sscanf(line, "%s", word) == 1) && (word[0] != "#")) begin
                        commands.push_back(line);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // One host write through the four-phase port
    // Ack is due two clocks after req goes up, counting the port's sync stage
    task automatic write_config(input logic [duty_width-1:0] period,
                                input logic [count_width-1:0] request);
        int edges;
        @(posedge clock);
        cfg_data.period <= period;
        cfg_data.phase_request <= request;
        cfg_req <= 1'b1;
        current_period = period;
        edges = 0;
        @(negedge clock);
        while (!cfg_ack) begin
            @(negedge clock);
            edges++;
        end
        checks++;
        test_checks++;
        if (edges != 2) begin
            $display("[ERROR] cfg_ack latency expected 0x2 got 0x%0h", edges);
            count_error();
        end
        // Release req and let the port close the transfer
        @(posedge clock);
        cfg_req <= 1'b0;
        @(negedge clock);
        while (cfg_ack) begin
            @(negedge clock);
        end
    endtask

    // duty_out is registered one clock behind duty_in
    task automatic drive_duty(input duty_vec_t value);
        @(posedge clock);
        duty_in <= value;
        @(posedge clock);
    endtask

    task automatic wait_for_active(input logic [count_width-1:0] target);
        @(negedge clock);
        while (active != target) begin
            @(negedge clock);
        end
        // The seed loads one clock after the step, and duty_out follows a clock later
        repeat (2) @(negedge clock);
    endtask

    // High clocks of one gate over exactly one switching period
    task automatic count_gate_high(input int phase, output logic [31:0] total);
        total = 0;
        repeat (current_period) begin
            @(negedge clock);
            total = total + gate[phase];
        end
    endtask

    task automatic check_signal(input string what, input int index,
                                input logic [31:0] expected);
        logic [31:0] actual;
        string name;
        bit known;
        known = 1'b1;
        actual = '0;
        name = what;
        if (what == "hicount") begin
            count_gate_high(index, actual);
            name = $sformatf("gate[%0d] high count", index);
        end else begin
            // Outputs are sampled half a clock away from the drive edge
            @(negedge clock);
            case (what)
                "ack": begin
                    actual = 32'(cfg_ack);
                    name = "cfg_ack";
                end
                "active": actual = 32'(active);
                "gate": actual = 32'(gate);
                "duty": begin
                    actual = 32'(duty_out[index] & 16'hffff);
                    name = $sformatf("duty_out[%0d]", index);
                end
                default: known = 1'b0;
            endcase
        end
        if (!known) begin
            $display("Unknown signal %s in an expect line", what);
            count_error();
        end else begin
            checks++;
            test_checks++;
            if (actual !== expected) begin
                $display("[ERROR] %s expected 0x%0h got 0x%0h", name, expected, actual);
                count_error();
            end
        end
    endtask

    task automatic report_malformed(input string line);
        $display("Stimulus line has the wrong number of fields: %s", line);
        count_error();
    endtask

    task automatic run_command(input string line);
        string cmd;
        string what;
        int fields;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        duty_vec_t value;
        fields = $sscanf(line, "%s", cmd);
        case (cmd)
            "test": begin
                fields = $sscanf(line, "%s %s", cmd, what);
                if (fields == 2) open_test(what);
                else report_malformed(line);
            end
            "cfg": begin
                fields = $sscanf(line, "%s %h %h", cmd, a, b);
                if (fields == 3) write_config(a[duty_width-1:0], b[count_width-1:0]);
                else report_malformed(line);
            end
            "duty": begin
                fields = $sscanf(line, "%s %h %h %h %h", cmd, a, b, c, d);
                value[0] = a[duty_width-1:0];
                value[1] = b[duty_width-1:0];
                value[2] = c[duty_width-1:0];
                value[3] = d[duty_width-1:0];
                if (fields == 5) drive_duty(value);
                else report_malformed(line);
            end
            "wait": begin
                fields = $sscanf(line, "%s %h", cmd, a);
                if (fields == 2) wait_for_active(a[count_width-1:0]);
                else report_malformed(line);
            end
            "expect": begin
                fields = $sscanf(line, "%s %s %h %h", cmd, what, a, b);
                if (fields == 4) check_signal(what, a, b);
                else report_malformed(line);
            end
            default: begin
                $display("Unknown stimulus command %s", cmd);
                count_error();
            end
        endcase
    endtask

    // The active count may only move by one, and never inside the settle interval
    always @(negedge clock) begin
        if (reset) begin
            last_active = count_width'(1);
            cycles_since_step = settle_cycles;
        end else begin
            cycles_since_step++;
            if (active != last_active) begin
                if ((active != last_active + 1) && (active + 1 != last_active)) begin
                    $display("[ERROR] active stepped from 0x%0h to 0x%0h",
                             last_active, active);
                    count_error();
                end
                if (cycles_since_step < settle_cycles) begin
                    $display("Active count changed only %0d clocks after the last change",
                             cycles_since_step);
                    count_error();
                end
                cycles_since_step = 0;
                last_active = active;
            end
        end
    end

    // Allow 64 clocks per stimulus line
    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clock);
        $display("Timeout: the stimulus did not finish within %0d clocks", watchdog_cycles);
        count_error();
        report_summary();
    end

    initial begin
        reset = 1'b1;
        cfg_req = 1'b0;
        cfg_data = '0;
        duty_in = '0;
        load_stimulus();
        if (commands.size() == 0) begin
            $display("No stimulus commands were loaded");
            errors++;
        end else begin
            watchdog_cycles = commands.size() * 64;
            repeat (3) @(posedge clock);
            reset <= 1'b0;
            foreach (commands[i]) begin
                run_command(commands[i]);
            end
        end
        report_summary();
    end

endmodule

//--- tb/buck_stimulus.txt
# cfg <period> <request> | duty <d0> <d1> <d2> <d3> | wait <active>
# expect <ack|active|gate|duty|hicount> <index> <value> | test <name>, all numbers in hex
test reset
expect ack 0 0
expect gate 0 0
expect active 0 1
test handshake
cfg 100 0
wait 1
expect active 0 1
expect ack 0 0
test addition
duty 40 10 20 30
cfg 100 3
wait 3
expect active 0 3
expect duty 0 40
expect duty 1 50
expect duty 2 60
expect duty 3 30
test clamp_high
cfg 100 7
wait 4
expect active 0 4
expect duty 3 70
test saturation
duty 55 FF80 30 C0
expect duty 0 55
expect duty 1 0
expect duty 2 70
expect duty 3 FF
duty FFF0 FFC0 BF 7FFF
expect duty 0 FFF0
expect duty 1 0
expect duty 2 FF
expect duty 3 FF
test shedding
cfg 100 1
wait 1
expect active 0 1
duty 20 11 22 33
expect duty 1 11
expect duty 2 22
expect duty 3 33
duty 60 11 22 33
cfg 100 2
wait 2
expect active 0 2
expect duty 1 71
expect duty 2 22
test gating
duty 08 FFC0 10 30
cfg 40 3
wait 3
expect active 0 3
expect duty 0 8
expect duty 1 20
expect duty 2 18
expect duty 3 30
expect hicount 0 8
expect hicount 1 20
expect hicount 2 18
expect hicount 3 0

//--- compile.f
hdl/buck_pkg.sv
hdl/phase_config_port.sv
hdl/phase_sequencer.sv
hdl/shedding_manager.sv
hdl/pwm_carrier.sv
hdl/buck_phase_top.sv
tb/buck_phase_assertions.sv
tb/tb_buck_phase.sv
